// File: Makefile
# Verilator build and run of the issue core testbench

OBJ_DIR := obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build issue_tb with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing -j 0 --top-module issue_tb -Mdir $(OBJ_DIR) -f list.f
	./$(OBJ_DIR)/Vissue_tb

clean:
	rm -rf $(OBJ_DIR)

// File: dv/issue_tb.sv
`timescale 1ns/1ns

module issue_tb import ooo_pkg::*; ();

    localparam int NUM_TAGS       = 1 << TAG_W;
    localparam int ALU_COUNT      = 10;
    localparam int MUL_COUNT      = 8;
    localparam int CHAIN_COUNT    = 9;
    localparam int PRESSURE_COUNT = 15;
    localparam int RANDOM_COUNT   = 60;
    localparam int TOTAL_INSTR    = ALU_COUNT + MUL_COUNT + CHAIN_COUNT + PRESSURE_COUNT
                                    + RANDOM_COUNT;
    localparam int TIMEOUT_CYCLES = TOTAL_INSTR * 40;

    logic     clock;
    logic     reset;
    logic     in_valid;
    logic     in_ready;
    op_e      in_op;
    operand_t in_src1;
    operand_t in_src2;
    tag_t     in_dest;
    logic     cdb_valid;
    tag_t     cdb_tag;
    data_t    cdb_value;

    // scoreboard, indexed by tag
    logic  pending [NUM_TAGS];
    logic  seen    [NUM_TAGS];
    data_t exp_val [NUM_TAGS];
    int    outstanding;
    int    next_tag;
    int    cycles = 0;
    logic  stall_seen;

    issue_top issue_top_i (
        .clock     (clock),
        .reset     (reset),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_op     (in_op),
        .in_src1   (in_src1),
        .in_src2   (in_src2),
        .in_dest   (in_dest),
        .cdb_valid (cdb_valid),
        .cdb_tag   (cdb_tag),
        .cdb_value (cdb_value)
    );

    initial begin
        clock = 1'b0;
        forever #50 clock = ~clock;
    end

    task automatic stop_on_failure(input string reason);
        $display("%s", reason);
        $display("SOME TESTS FAILED");
        $fatal(1, "run stopped at the first failure");
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            stop_on_failure($sformatf("Error at %0t: %s = %b, expected %b",
                                      $time, name, got, exp));
        end
    endtask

    task automatic check_data(input string name, input data_t got, input data_t exp);
        if (got !== exp) begin
            stop_on_failure($sformatf("Error at %0t: %s = %h, expected %h",
                                      $time, name, got, exp));
        end
    endtask

    // a broadcast tag must be outstanding and not yet returned
    task automatic check_tag(input tag_t got);
        if (!pending[got]) begin
            if (seen[got]) begin
                stop_on_failure($sformatf("tag %0d came back on the CDB a second time at %0t",
                                          got, $time));
            end else begin
                stop_on_failure($sformatf("tag %0d appeared on the CDB but was never issued at %0t",
                                          got, $time));
            end
        end
    endtask

    function automatic data_t expected_result(op_e op, data_t a, data_t b);
        case (op)
            OP_ADD:  return a + b;
            OP_SUB:  return a - b;
            OP_AND:  return a & b;
            OP_OR:   return a | b;
            OP_XOR:  return a ^ b;
            default: return a * b;
        endcase
    endfunction

    function automatic operand_t ready_operand(data_t v);
        operand_t o;
        o.ready = 1'b1;
        o.tag   = '0;
        o.value = v;
        return o;
    endfunction

    // value field keeps the producer's expected result for the model
    function automatic operand_t waiting_operand(tag_t t);
        operand_t o;
        o.ready = 1'b0;
        o.tag   = t;
        o.value = exp_val[t];
        return o;
    endfunction

    // a producer that already left the CDB can no longer be caught by the DUT
    function automatic operand_t resolve_operand(operand_t src);
        operand_t o;
        o = src;
        if (!src.ready && !pending[src.tag] && !(cdb_valid && cdb_tag == src.tag)) begin
            o.ready = 1'b1;
        end
        return o;
    endfunction

    function automatic tag_t free_tag();
        tag_t t;
        tag_t pick;
        logic found;
        pick  = '0;
        found = 1'b0;
        for (int i = 0; i < NUM_TAGS; i++) begin
            t = tag_t'(next_tag + i);
            if (!found && !pending[t] && !(cdb_valid && cdb_tag == t)) begin
                pick  = t;
                found = 1'b1;
            end
        end
        next_tag = int'(pick) + 1;
        return pick;
    endfunction

    // called at a falling edge, returns at the falling edge after the accept
    task automatic send(input op_e op, input operand_t s1, input operand_t s2,
                        output tag_t dest);
        dest          = free_tag();
        exp_val[dest] = expected_result(op, s1.value, s2.value);
        pending[dest] = 1'b1;
        seen[dest]    = 1'b0;
        outstanding++;
        in_valid = 1'b1;
        in_op    = op;
        in_dest  = dest;
        in_src1  = resolve_operand(s1);
        in_src2  = resolve_operand(s2);
        while (!in_ready) begin
            stall_seen = 1'b1;
            @(negedge clock);
            in_src1 = resolve_operand(s1);
            in_src2 = resolve_operand(s2);
        end
        @(negedge clock);
        in_valid = 1'b0;
    endtask

    task automatic wait_for_drain();
        while (outstanding != 0) begin
            @(negedge clock);
        end
    endtask

    // cdb monitor
    always @(negedge clock) begin
        if (reset === 1'b0 && cdb_valid) begin
            check_tag(cdb_tag);
            check_data($sformatf("cdb_value (tag %0d)", cdb_tag), cdb_value, exp_val[cdb_tag]);
            pending[cdb_tag] = 1'b0;
            seen[cdb_tag]    = 1'b1;
            outstanding--;
        end
    end

    always @(posedge clock) begin
        cycles++;
        if (cycles > TIMEOUT_CYCLES) begin
            stop_on_failure($sformatf("timeout after %0d cycles, %0d results never arrived",
                                      cycles, outstanding));
        end
    end

    // in_ready rises one edge after reset
    task automatic check_after_reset();
        check_flag("cdb_valid", cdb_valid, 1'b0);
        check_flag("in_ready", in_ready, 1'b0);
        @(negedge clock);
        check_flag("cdb_valid", cdb_valid, 1'b0);
        check_flag("in_ready", in_ready, 1'b1);
    endtask

    task automatic test_alu_ops();
        tag_t t;
        for (int i = 0; i < ALU_COUNT; i++) begin
            send(op_e'(i % 5), ready_operand($urandom), ready_operand($urandom), t);
        end
        wait_for_drain();
    endtask

    // every fourth one is an ALU op so completions interleave
    task automatic test_multiplies();
        tag_t t;
        op_e  op;
        for (int i = 0; i < MUL_COUNT; i++) begin
            op = (i % 4 == 3) ? OP_XOR : OP_MUL;
            send(op, ready_operand($urandom), ready_operand($urandom), t);
        end
        wait_for_drain();
    endtask

    task automatic test_dependency_chain();
        tag_t prev;
        tag_t next;
        op_e  op;
        send(OP_ADD, ready_operand($urandom), ready_operand($urandom), prev);
        for (int i = 0; i < CHAIN_COUNT - 1; i++) begin
            op = (i % 2 == 0) ? OP_MUL : op_e'(i % 5);
            send(op, waiting_operand(prev), ready_operand($urandom_range(1, 9)), next);
            prev = next;
        end
        wait_for_drain();
    endtask

    // three chained multiplies keep the tail waiting long enough to fill the station
    task automatic test_back_pressure();
        tag_t root;
        tag_t mid;
        tag_t tail;
        tag_t t;
        op_e  op;
        stall_seen = 1'b0;
        send(OP_MUL, ready_operand($urandom), ready_operand($urandom), root);
        send(OP_MUL, waiting_operand(root), ready_operand(32'd3), mid);
        send(OP_MUL, waiting_operand(mid), ready_operand(32'd5), tail);
        for (int i = 0; i < PRESSURE_COUNT - 3; i++) begin
            op = (i % 4 == 0) ? OP_MUL : op_e'(i % 5);
            send(op, waiting_operand(tail), ready_operand($urandom), t);
        end
        wait_for_drain();
        if (!stall_seen) begin
            stop_on_failure("in_ready never dropped while the station was full");
        end
    endtask

    // depends on an outstanding tag about half the time
    function automatic operand_t pick_operand();
        int   start;
        tag_t t;
        tag_t pick;
        logic found;
        start = int'($urandom_range(0, NUM_TAGS - 1));
        pick  = '0;
        found = 1'b0;
        if ($urandom_range(0, 1) == 1) begin
            for (int i = 0; i < NUM_TAGS; i++) begin
                t = tag_t'(start + i);
                if (!found && pending[t]) begin
                    pick  = t;
                    found = 1'b1;
                end
            end
        end
        if (found) begin
            return waiting_operand(pick);
        end
        return ready_operand($urandom);
    endfunction

    task automatic test_random_mix();
        op_e      op;
        operand_t s1;
        operand_t s2;
        tag_t     t;
        for (int n = 0; n < RANDOM_COUNT; n++) begin
            op = op_e'($urandom_range(0, 5));
            s1 = pick_operand();
            s2 = pick_operand();
            send(op, s1, s2, t);
            if ($urandom_range(0, 3) == 0) begin
                @(negedge clock);
            end
        end
        wait_for_drain();
    endtask

    initial begin
        void'($urandom(32'h2d96));
        reset       = 1'b1;
        in_valid    = 1'b0;
        in_op       = OP_ADD;
        in_src1     = '0;
        in_src2     = '0;
        in_dest     = '0;
        outstanding = 0;
        next_tag    = 0;
        stall_seen  = 1'b0;
        for (int i = 0; i < NUM_TAGS; i++) begin
            pending[i] = 1'b0;
            seen[i]    = 1'b0;
            exp_val[i] = '0;
        end
        repeat (16) @(negedge clock);
        reset = 1'b0;
        check_after_reset();
        test_alu_ops();
        test_multiplies();
        test_dependency_chain();
        test_back_pressure();
        test_random_mix();
        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

// File: list.f
src/ooo_pkg.sv
src/ooo_ifs.sv
src/dispatch_stage.sv
src/res_station.sv
src/alu_unit.sv
src/mult_unit.sv
src/cdb_arbiter.sv
src/issue_top.sv
dv/issue_tb.sv

// File: src/alu_unit.sv
`timescale 1ns/1ns

module alu_unit import ooo_pkg::*; (
    input  logic        clock,
    input  logic        reset,
    fu_issue_if.sink    iss,
    result_if.source    res
);

    logic  out_valid;
    tag_t  out_tag;
    data_t out_value;
    data_t result;
    logic  fire;

    always_comb begin
        case (iss.op)
            OP_ADD:  result = iss.a + iss.b;
            OP_SUB:  result = iss.a - iss.b;
            OP_AND:  result = iss.a & iss.b;
            OP_OR:   result = iss.a | iss.b;
            OP_XOR:  result = iss.a ^ iss.b;
            default: result = '0;
        endcase
    end

    // free when empty or leaving this cycle
    assign iss.avail = !out_valid || res.take;
    assign fire      = iss.valid && iss.avail;

    always_ff @(posedge clock) begin
        if (reset) begin
            out_valid <= 1'b0;
        end else if (fire) begin
            out_valid <= 1'b1;
        end else if (res.take) begin
            out_valid <= 1'b0;
        end
    end

    always_ff @(posedge clock) begin
        if (fire) begin
            out_tag   <= iss.dest;
            out_value <= result;
        end
    end

    assign res.valid = out_valid;
    assign res.tag   = out_tag;
    assign res.value = out_value;

endmodule

// File: src/cdb_arbiter.sv
`timescale 1ns/1ns

module cdb_arbiter import ooo_pkg::*; (
    input  logic        clock,
    input  logic        reset,
    result_if.sink      alu_res,
    result_if.sink      mul_res,
    output logic        cdb_valid,
    output tag_t        cdb_tag,
    output data_t       cdb_value
);

    logic  win_valid;
    tag_t  win_tag;
    data_t win_value;

    // multiplier cannot hold its result, so it always wins
    assign mul_res.take = mul_res.valid;
    assign alu_res.take = alu_res.valid && !mul_res.valid;

    always_comb begin
        if (mul_res.valid) begin
            win_valid = 1'b1;
            win_tag   = mul_res.tag;
            win_value = mul_res.value;
        end else begin
            win_valid = alu_res.valid;
            win_tag   = alu_res.tag;
            win_value = alu_res.value;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            cdb_valid <= 1'b0;
        end else begin
            cdb_valid <= win_valid;
        end
    end

    always_ff @(posedge clock) begin
        cdb_tag   <= win_tag;
        cdb_value <= win_value;
    end

endmodule

// File: src/dispatch_stage.sv
`timescale 1ns/1ns

module dispatch_stage import ooo_pkg::*; (
    input  logic          clock,
    input  logic          reset,
    input  logic          in_valid,
    output logic          in_ready,
    input  op_e           in_op,
    input  operand_t      in_src1,
    input  operand_t      in_src2,
    input  tag_t          in_dest,
    input  logic          cdb_valid,
    input  tag_t          cdb_tag,
    input  data_t         cdb_value,
    rs_write_if.source    wr
);

    logic     started;
    logic     hold_valid;
    op_e      op_q;
    operand_t src1_q;
    operand_t src2_q;
    tag_t     dest_q;
    logic     drain;
    logic     accept;

    assign drain    = hold_valid && (wr.free_count != '0);
    // ready stays low until one edge after reset
    assign in_ready = started && (!hold_valid || drain);
    assign accept   = in_valid && in_ready;

    // sources are patched on the way out so a same-cycle broadcast is not lost
    assign wr.valid = drain;
    assign wr.entry = rs_entry_t'{
        valid: 1'b1,
        op:    op_q,
        src1:  wake_operand(src1_q, cdb_valid, cdb_tag, cdb_value),
        src2:  wake_operand(src2_q, cdb_valid, cdb_tag, cdb_value),
        dest:  dest_q,
        age:   '0
    };

    always_ff @(posedge clock) begin
        if (reset) begin
            started    <= 1'b0;
            hold_valid <= 1'b0;
        end else begin
            started <= 1'b1;
            if (accept) begin
                hold_valid <= 1'b1;
            end else if (drain) begin
                hold_valid <= 1'b0;
            end
        end
    end

    // payload, keeps snooping while held
    always_ff @(posedge clock) begin
        if (accept) begin
            op_q   <= in_op;
            src1_q <= wake_operand(in_src1, cdb_valid, cdb_tag, cdb_value);
            src2_q <= wake_operand(in_src2, cdb_valid, cdb_tag, cdb_value);
            dest_q <= in_dest;
        end else begin
            src1_q <= wake_operand(src1_q, cdb_valid, cdb_tag, cdb_value);
            src2_q <= wake_operand(src2_q, cdb_valid, cdb_tag, cdb_value);
        end
    end

endmodule

// File: src/issue_top.sv
`timescale 1ns/1ns

module issue_top import ooo_pkg::*; (
    input  logic     clock,
    input  logic     reset,
    input  logic     in_valid,
    output logic     in_ready,
    input  op_e      in_op,
    input  operand_t in_src1,
    input  operand_t in_src2,
    input  tag_t     in_dest,
    output logic     cdb_valid,
    output tag_t     cdb_tag,
    output data_t    cdb_value
);

    rs_write_if wr_if ();
    fu_issue_if alu_iss_if ();
    fu_issue_if mul_iss_if ();
    result_if   alu_res_if ();
    result_if   mul_res_if ();

    dispatch_stage dispatch_stage_i (
        .clock     (clock),
        .reset     (reset),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_op     (in_op),
        .in_src1   (in_src1),
        .in_src2   (in_src2),
        .in_dest   (in_dest),
        .cdb_valid (cdb_valid),
        .cdb_tag   (cdb_tag),
        .cdb_value (cdb_value),
        .wr        (wr_if)
    );

    res_station res_station_i (
        .clock     (clock),
        .reset     (reset),
        .wr        (wr_if),
        .cdb_valid (cdb_valid),
        .cdb_tag   (cdb_tag),
        .cdb_value (cdb_value),
        .alu_iss   (alu_iss_if),
        .mul_iss   (mul_iss_if)
    );

    alu_unit alu_unit_i (
        .clock (clock),
        .reset (reset),
        .iss   (alu_iss_if),
        .res   (alu_res_if)
    );

    mult_unit mult_unit_i (
        .clock (clock),
        .reset (reset),
        .iss   (mul_iss_if),
        .res   (mul_res_if)
    );

    cdb_arbiter cdb_arbiter_i (
        .clock     (clock),
        .reset     (reset),
        .alu_res   (alu_res_if),
        .mul_res   (mul_res_if),
        .cdb_valid (cdb_valid),
        .cdb_tag   (cdb_tag),
        .cdb_value (cdb_value)
    );

endmodule

// File: src/mult_unit.sv
`timescale 1ns/1ns

module mult_unit import ooo_pkg::*; (
    input  logic        clock,
    input  logic        reset,
    fu_issue_if.sink    iss,
    result_if.source    res
);

    logic                   started;
    logic [MULT_STAGES-1:0] vld;
    tag_t                   tag_q  [MULT_STAGES];
    data_t                  a_q;
    data_t                  b_q;
    data_t                  prod_q [1:MULT_STAGES-1];

    // never stalls, the arbiter always takes our result
    assign iss.avail = started;

    always_ff @(posedge clock) begin
        if (reset) begin
            started <= 1'b0;
            vld     <= '0;
        end else begin
            started <= 1'b1;
            vld     <= {vld[MULT_STAGES-2:0], iss.valid && iss.avail};
        end
    end

    // stage 0 operands, stage 1 product, then plain delay
    always_ff @(posedge clock) begin
        a_q      <= iss.a;
        b_q      <= iss.b;
        tag_q[0] <= iss.dest;
        prod_q[1] <= a_q * b_q;
        for (int s = 1; s < MULT_STAGES; s++) begin
            tag_q[s] <= tag_q[s-1];
        end
        for (int s = 2; s < MULT_STAGES; s++) begin
            prod_q[s] <= prod_q[s-1];
        end
    end

    assign res.valid = vld[MULT_STAGES-1];
    assign res.tag   = tag_q[MULT_STAGES-1];
    assign res.value = prod_q[MULT_STAGES-1];

endmodule

// File: src/ooo_ifs.sv
`timescale 1ns/1ns

// dispatch register into the station
interface rs_write_if import ooo_pkg::*; ();
    logic      valid;
    rs_entry_t entry;
    count_t    free_count;

    modport source (output valid, output entry, input free_count);
    modport sink   (input valid, input entry, output free_count);
endinterface

// station to one functional unit
interface fu_issue_if import ooo_pkg::*; ();
    logic  valid;
    op_e   op;
    data_t a;
    data_t b;
    tag_t  dest;
    logic  avail;

    modport source (output valid, output op, output a, output b, output dest, input avail);
    modport sink   (input valid, input op, input a, input b, input dest, output avail);
endinterface

// unit result towards the cdb arbiter
interface result_if import ooo_pkg::*; ();
    logic  valid;
    tag_t  tag;
    data_t value;
    logic  take;

    modport source (output valid, output tag, output value, input take);
    modport sink   (input valid, input tag, input value, output take);
endinterface

// File: src/ooo_pkg.sv
package ooo_pkg;

    // station and datapath sizing
    localparam int RS_SIZE     = 8;
    localparam int TAG_W       = 5;
    localparam int DATA_W      = 32;
    localparam int MULT_STAGES = 3;
    localparam int AGE_W       = 8;
    localparam int IDX_W       = $clog2(RS_SIZE);
    localparam int CNT_W       = $clog2(RS_SIZE + 1);

    typedef logic [TAG_W-1:0]  tag_t;
    typedef logic [DATA_W-1:0] data_t;
    typedef logic [AGE_W-1:0]  age_t;
    typedef logic [CNT_W-1:0]  count_t;

    typedef enum logic [2:0] {
        OP_ADD = 3'd0,
        OP_SUB = 3'd1,
        OP_AND = 3'd2,
        OP_OR  = 3'd3,
        OP_XOR = 3'd4,
        OP_MUL = 3'd5
    } op_e;

    typedef enum logic {
        FU_ALU  = 1'b0,
        FU_MULT = 1'b1
    } fu_e;

    // value is only meaningful once ready is set
    typedef struct packed {
        logic  ready;
        tag_t  tag;
        data_t value;
    } operand_t;

    typedef struct packed {
        logic     valid;
        op_e      op;
        operand_t src1;
        operand_t src2;
        tag_t     dest;
        age_t     age;
    } rs_entry_t;

    // capture a matching cdb broadcast into a waiting operand
    function automatic operand_t wake_operand(operand_t src, logic cdb_valid,
                                              tag_t cdb_tag, data_t cdb_value);
        operand_t woken;
        woken = src;
        if (cdb_valid && !src.ready && src.tag == cdb_tag) begin
            woken.ready = 1'b1;
            woken.value = cdb_value;
        end
        return woken;
    endfunction

endpackage

// File: src/res_station.sv
`timescale 1ns/1ns

module res_station import ooo_pkg::*; (
    input  logic          clock,
    input  logic          reset,
    rs_write_if.sink      wr,
    input  logic          cdb_valid,
    input  tag_t          cdb_tag,
    input  data_t         cdb_value,
    fu_issue_if.source    alu_iss,
    fu_issue_if.source    mul_iss
);

    rs_entry_t          entries [RS_SIZE];
    age_t               age_ctr;
    logic [RS_SIZE-1:0] alu_req;
    logic [RS_SIZE-1:0] mul_req;
    logic [IDX_W-1:0]   alu_idx;
    logic [IDX_W-1:0]   mul_idx;
    logic [IDX_W-1:0]   wr_idx;
    count_t             free_cnt;

    function automatic fu_e fu_of(op_e op);
        return (op == OP_MUL) ? FU_MULT : FU_ALU;
    endfunction

    // wrap-safe age compare, true when a was stamped before b
    function automatic logic is_older(age_t a, age_t b);
        age_t diff;
        diff = a - b;
        return diff[AGE_W-1];
    endfunction

    function automatic logic [IDX_W-1:0] pick_oldest(logic [RS_SIZE-1:0] req);
        logic [IDX_W-1:0] best;
        logic             found;
        best  = '0;
        found = 1'b0;
        for (int i = 0; i < RS_SIZE; i++) begin
            if (req[i] && (!found || is_older(entries[i].age, entries[best].age))) begin
                best  = IDX_W'(i);
                found = 1'b1;
            end
        end
        return best;
    endfunction

    // per-class request masks
    always_comb begin
        logic rdy;
        for (int i = 0; i < RS_SIZE; i++) begin
            rdy        = entries[i].valid && entries[i].src1.ready && entries[i].src2.ready;
            alu_req[i] = rdy && (fu_of(entries[i].op) == FU_ALU);
            mul_req[i] = rdy && (fu_of(entries[i].op) == FU_MULT);
        end
    end

    assign alu_idx = pick_oldest(alu_req);
    assign mul_idx = pick_oldest(mul_req);

    // lowest free slot and free count
    always_comb begin
        wr_idx   = '0;
        free_cnt = '0;
        for (int i = RS_SIZE - 1; i >= 0; i--) begin
            if (!entries[i].valid) begin
                wr_idx   = IDX_W'(i);
                free_cnt = free_cnt + 1'b1;
            end
        end
    end

    assign wr.free_count = free_cnt;

    assign alu_iss.valid = (|alu_req) && alu_iss.avail;
    assign alu_iss.op    = entries[alu_idx].op;
    assign alu_iss.a     = entries[alu_idx].src1.value;
    assign alu_iss.b     = entries[alu_idx].src2.value;
    assign alu_iss.dest  = entries[alu_idx].dest;

    assign mul_iss.valid = (|mul_req) && mul_iss.avail;
    assign mul_iss.op    = entries[mul_idx].op;
    assign mul_iss.a     = entries[mul_idx].src1.value;
    assign mul_iss.b     = entries[mul_idx].src2.value;
    assign mul_iss.dest  = entries[mul_idx].dest;

    always_ff @(posedge clock) begin
        if (reset) begin
            age_ctr <= '0;
            for (int i = 0; i < RS_SIZE; i++) begin
                entries[i].valid <= 1'b0;
            end
        end else begin
            // wakeup of stored operands
            for (int i = 0; i < RS_SIZE; i++) begin
                entries[i].src1 <= wake_operand(entries[i].src1, cdb_valid, cdb_tag, cdb_value);
                entries[i].src2 <= wake_operand(entries[i].src2, cdb_valid, cdb_tag, cdb_value);
            end
            if (alu_iss.valid) begin
                entries[alu_idx].valid <= 1'b0;
            end
            if (mul_iss.valid) begin
                entries[mul_idx].valid <= 1'b0;
            end
            // new entry lands in a slot that was empty, never one issuing now
            if (wr.valid) begin
                entries[wr_idx]     <= wr.entry;
                entries[wr_idx].age <= age_ctr;
                age_ctr             <= age_ctr + 1'b1;
            end
        end
    end

endmodule
